// ==== logic/rv_lite_config.svh ====
`ifndef RV_LITE_CONFIG_SVH
`define RV_LITE_CONFIG_SVH

// Data and address width
`define RV_XLEN 32
`define RV_REG_COUNT 32

`define RV_RESET_PC 32'h0000_0000
`define RV_PC_STEP 4 // Bytes per instruction

`endif

// ==== logic/rv_lite_pkg.sv ====
package rv_lite_pkg;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_e;

  // One instruction word, four ways to read its fields
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2, rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_view;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2, rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_view;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_view;
  } instr_u;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;
    logic    reg_write;
    logic    is_branch;
    logic    branch_ne; // BNE, else BEQ
    logic    is_jal;
  } dec_ctrl_t;

endpackage

// ==== logic/exec_if.sv ====
`timescale 1ns/1ps
`include "rv_lite_config.svh"

interface exec_if (input logic clk_i);
  import rv_lite_pkg::*;

  logic               valid;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] imm;
  logic [4:0]          rd;
  dec_ctrl_t           ctrl;

  modport decode (output valid, pc, rs1_data, rs2_data, imm, rd, ctrl);
  modport alu (input clk_i, valid, rs1_data, rs2_data, imm, ctrl); // clk_i for checks only
  modport branch (input pc, rs1_data, rs2_data, imm, ctrl);
  modport wb (input clk_i, valid, pc, rd, ctrl);

endinterface

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`include "rv_lite_config.svh"

module fetch_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic                redirect_i,
  input  logic [`RV_XLEN-1:0] redirect_pc_i,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  output logic                imem_req_o,
  output logic                fetch_valid_o,
  output logic [`RV_XLEN-1:0] fetch_pc_o
);

  logic [`RV_XLEN-1:0] pc_q;
  logic                run_q;

  assign imem_req_o  = run_q;
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q         <= 1'b0;
      pc_q          <= `RV_RESET_PC;
      fetch_valid_o <= 1'b0;
    end else begin
      if (start_i) run_q <= 1'b1; // Stays set once running
      if (redirect_i) pc_q <= redirect_pc_i;
      else if (run_q) pc_q <= pc_q + `RV_PC_STEP;
      // Request issued in the redirect cycle is on the wrong path
      fetch_valid_o <= run_q && !redirect_i;
    end
  end

  // Address of the word that arrives next cycle
  always_ff @(posedge clk_i) begin
    fetch_pc_o <= pc_q;
  end

  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pc_q[1:0] == 2'b00);

endmodule

// ==== logic/decode_unit.sv ====
`timescale 1ns/1ps
`include "rv_lite_config.svh"

module decode_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  rv_lite_pkg::instr_u instr_i,
  input  logic                fetch_valid_i,
  input  logic [`RV_XLEN-1:0] fetch_pc_i,
  input  logic                kill_i,
  input  logic                wr_en_i,
  input  logic [4:0]          wr_addr_i,
  input  logic [`RV_XLEN-1:0] wr_data_i,
  exec_if.decode              ex
);
  import rv_lite_pkg::*;

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
  logic [`RV_XLEN-1:0] imm_d;
  logic [`RV_XLEN-1:0] rs1_data, rs2_data;
  dec_ctrl_t           ctrl_d;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) regs[wr_addr_i] <= wr_data_i;
  end

  // x0 reads as zero; a write in this cycle is seen by the read
  always_comb begin
    rs1_data = regs[instr_i.r_view.rs1];
    rs2_data = regs[instr_i.r_view.rs2];
    if (wr_en_i && wr_addr_i == instr_i.r_view.rs1) rs1_data = wr_data_i;
    if (wr_en_i && wr_addr_i == instr_i.r_view.rs2) rs2_data = wr_data_i;
    if (instr_i.r_view.rs1 == 5'd0) rs1_data = '0;
    if (instr_i.r_view.rs2 == 5'd0) rs2_data = '0;
  end

  always_comb begin
    ctrl_d        = '0;
    ctrl_d.alu_op = ALU_ADD;
    imm_d         = '0;
    case (instr_i.r_view.opcode)
      OPC_OP: begin
        ctrl_d.reg_write = 1'b1;
        case (instr_i.r_view.funct3)
          3'b000: ctrl_d.alu_op = instr_i.r_view.funct7[5] ? ALU_SUB : ALU_ADD;
          3'b010: ctrl_d.alu_op = ALU_SLT;
          3'b100: ctrl_d.alu_op = ALU_XOR;
          3'b110: ctrl_d.alu_op = ALU_OR;
          3'b111: ctrl_d.alu_op = ALU_AND;
          default: ctrl_d.reg_write = 1'b0; // Shifts, SLTU
        endcase
      end
      OPC_OP_IMM: begin
        ctrl_d.use_imm   = 1'b1;
        ctrl_d.reg_write = (instr_i.i_view.funct3 == 3'b000); // ADDI only
        imm_d = {{(`RV_XLEN-12){instr_i.i_view.imm[11]}}, instr_i.i_view.imm};
      end
      OPC_LUI: begin
        ctrl_d.use_imm   = 1'b1;
        ctrl_d.reg_write = 1'b1;
        ctrl_d.alu_op    = ALU_PASS_B;
        imm_d = {instr_i.r_view.funct7, instr_i.r_view.rs2, instr_i.r_view.rs1,
                 instr_i.r_view.funct3, 12'b0};
      end
      OPC_BRANCH: begin
        ctrl_d.is_branch = (instr_i.b_view.funct3[2:1] == 2'b00); // BEQ, BNE
        ctrl_d.branch_ne = instr_i.b_view.funct3[0];
        imm_d = {{(`RV_XLEN-12){instr_i.b_view.imm_12}}, instr_i.b_view.imm_11,
                 instr_i.b_view.imm_10_5, instr_i.b_view.imm_4_1, 1'b0};
      end
      OPC_JAL: begin
        ctrl_d.is_jal    = 1'b1;
        ctrl_d.reg_write = 1'b1;
        imm_d = {{(`RV_XLEN-20){instr_i.j_view.imm_20}}, instr_i.j_view.imm_19_12,
                 instr_i.j_view.imm_11, instr_i.j_view.imm_10_1, 1'b0};
      end
      default: ; // Retires as a no-op
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) ex.valid <= 1'b0;
    else ex.valid <= fetch_valid_i && !kill_i;
  end

  always_ff @(posedge clk_i) begin
    ex.pc       <= fetch_pc_i;
    ex.rs1_data <= rs1_data;
    ex.rs2_data <= rs2_data;
    ex.imm      <= imm_d;
    ex.rd       <= instr_i.r_view.rd;
    ex.ctrl     <= ctrl_d;
  end

  // Write-back must filter x0 so regs[0] is never touched
  a_x0_unchanged: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_en_i |-> wr_addr_i != 5'd0);

endmodule

// ==== logic/alu_unit.sv ====
`timescale 1ns/1ps
`include "rv_lite_config.svh"

module alu_unit (
  exec_if.alu                 ex,
  output logic [`RV_XLEN-1:0] alu_result_o
);
  import rv_lite_pkg::*;

  logic [`RV_XLEN-1:0] op_a, op_b;

  assign op_a = ex.rs1_data;
  assign op_b = ex.ctrl.use_imm ? ex.imm : ex.rs2_data;

  always_comb begin
    case (ex.ctrl.alu_op)
      ALU_ADD:    alu_result_o = op_a + op_b;
      ALU_SUB:    alu_result_o = op_a - op_b;
      ALU_AND:    alu_result_o = op_a & op_b;
      ALU_OR:     alu_result_o = op_a | op_b;
      ALU_XOR:    alu_result_o = op_a ^ op_b;
      ALU_SLT: begin
        alu_result_o = '0;
        alu_result_o[0] = $signed(op_a) < $signed(op_b);
      end
      ALU_PASS_B: alu_result_o = op_b; // LUI
      default:    alu_result_o = '0;
    endcase
  end

  // Decode only ever emits the seven defined codes
  a_alu_op_known: assert property (@(posedge ex.clk_i)
    ex.valid |-> ex.ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                                         ALU_XOR, ALU_SLT, ALU_PASS_B});

endmodule

// ==== logic/branch_unit.sv ====
`timescale 1ns/1ps
`include "rv_lite_config.svh"

module branch_unit (
  exec_if.branch              ex,
  output logic                taken_o,
  output logic [`RV_XLEN-1:0] target_o,
  output logic [`RV_XLEN-1:0] link_o
);

  logic equal;
  logic cond;

  assign equal = (ex.rs1_data == ex.rs2_data);
  assign cond  = equal ^ ex.ctrl.branch_ne; // Inverted for BNE

  // JAL always jumps
  assign taken_o = ex.ctrl.is_jal || (ex.ctrl.is_branch && cond);

  // Branch and jump offsets are both PC relative
  assign target_o = ex.pc + ex.imm;
  assign link_o   = ex.pc + `RV_PC_STEP;

endmodule

// ==== logic/writeback_unit.sv ====
`timescale 1ns/1ps
`include "rv_lite_config.svh"

module writeback_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  exec_if.wb                  ex,
  input  logic [`RV_XLEN-1:0] alu_result_i,
  input  logic                taken_i,
  input  logic [`RV_XLEN-1:0] target_i,
  input  logic [`RV_XLEN-1:0] link_i,
  output logic                redirect_o,
  output logic [`RV_XLEN-1:0] redirect_pc_o,
  output logic                wr_en_o,
  output logic [4:0]          wr_addr_o,
  output logic [`RV_XLEN-1:0] wr_data_o,
  output logic                retire_valid_o,
  output logic [`RV_XLEN-1:0] retire_pc_o,
  output logic [4:0]          retire_rd_o,
  output logic [`RV_XLEN-1:0] retire_data_o
);

  assign wr_data_o = ex.ctrl.is_jal ? link_i : alu_result_i;
  assign wr_addr_o = ex.rd;
  assign wr_en_o   = ex.valid && ex.ctrl.reg_write && (ex.rd != 5'd0);

  assign redirect_o    = ex.valid && taken_i;
  assign redirect_pc_o = target_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) retire_valid_o <= 1'b0;
    else retire_valid_o <= ex.valid;
  end

  // Zero rd and data mark a retire without a register write
  always_ff @(posedge clk_i) begin
    retire_pc_o   <= ex.pc;
    retire_rd_o   <= wr_en_o ? ex.rd : 5'd0;
    retire_data_o <= wr_en_o ? wr_data_o : '0;
  end

  // A redirect comes from a live jump or branch, and the next slot is a bubble
  a_redirect_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    redirect_o |-> ex.valid && (ex.ctrl.is_branch || ex.ctrl.is_jal) ##1 !ex.valid);

endmodule

// ==== logic/rv_lite_core.sv ====
`timescale 1ns/1ps
`include "rv_lite_config.svh"

module rv_lite_core (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  output logic                imem_req_o,
  input  logic [31:0]         imem_data_i,
  output logic                retire_valid_o,
  output logic [`RV_XLEN-1:0] retire_pc_o,
  output logic [4:0]          retire_rd_o,
  output logic [`RV_XLEN-1:0] retire_data_o
);

  logic                redirect;
  logic [`RV_XLEN-1:0] redirect_pc;
  logic                fetch_valid;
  logic [`RV_XLEN-1:0] fetch_pc;
  logic                wr_en;
  logic [4:0]          wr_addr;
  logic [`RV_XLEN-1:0] wr_data;
  logic [`RV_XLEN-1:0] alu_result;
  logic                taken;
  logic [`RV_XLEN-1:0] target, link;

  exec_if u_ex (.clk_i(clk_i));

  fetch_unit u_fetch (
    .clk_i, .rst_n_i, .start_i,
    .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .imem_addr_o, .imem_req_o,
    .fetch_valid_o(fetch_valid), .fetch_pc_o(fetch_pc)
  );

  decode_unit u_decode (
    .clk_i, .rst_n_i, .instr_i(imem_data_i),
    .fetch_valid_i(fetch_valid), .fetch_pc_i(fetch_pc), .kill_i(redirect),
    .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data), .ex(u_ex.decode)
  );

  alu_unit u_alu (.ex(u_ex.alu), .alu_result_o(alu_result));

  branch_unit u_branch (.ex(u_ex.branch), .taken_o(taken), .target_o(target), .link_o(link));

  writeback_unit u_wb (
    .clk_i, .rst_n_i, .ex(u_ex.wb),
    .alu_result_i(alu_result), .taken_i(taken), .target_i(target), .link_i(link),
    .redirect_o(redirect), .redirect_pc_o(redirect_pc),
    .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
    .retire_valid_o, .retire_pc_o, .retire_rd_o, .retire_data_o
  );

endmodule

// ==== bench/tb_rv_lite_core.sv ====
`timescale 1ns/1ps
`include "rv_lite_config.svh"

module tb_rv_lite_core;

  localparam int NUM_INSTR       = 22;
  localparam int WATCHDOG_CYCLES = NUM_INSTR * 4 + 60;
  localparam logic [31:0] NOP_WORD = 32'h0000_0013; // addi x0, x0, 0

  logic                clk_i;
  logic                rst_n_i;
  logic                start_i;
  logic [`RV_XLEN-1:0] imem_addr_o;
  logic                imem_req_o;
  logic [31:0]         imem_data_i;
  logic                retire_valid_o;
  logic [`RV_XLEN-1:0] retire_pc_o;
  logic [4:0]          retire_rd_o;
  logic [`RV_XLEN-1:0] retire_data_o;

  logic [31:0]         prog_word [NUM_INSTR];
  logic [4:0]          prog_rd [NUM_INSTR]; // Expected retire rd, 0 when nothing is written
  logic [`RV_XLEN-1:0] exp_pc_q [$];
  logic [4:0]          exp_rd_q [$];
  logic [`RV_XLEN-1:0] exp_data_q [$];
  int                  errors;
  int                  checked;

  rv_lite_core u_rv_lite_core (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_word(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // BEQ when ne is low, BNE otherwise
  function automatic logic [31:0] branch_word(input logic ne, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic set_entry(input int idx, input logic [31:0] word, input logic [4:0] rd);
    prog_word[idx] = word;
    prog_rd[idx]   = rd;
  endtask

  task automatic load_program();
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [11:0] imm_c;
    imm_a = 12'($urandom());
    imm_b = 12'($urandom());
    imm_c = 12'($urandom());
    set_entry(0,  addi_word(imm_a, 5'd0, 5'd1), 5'd1);
    set_entry(1,  addi_word(imm_b, 5'd1, 5'd2), 5'd2); // Reads x1 through pass-through
    set_entry(2,  rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3);
    set_entry(3,  rtype_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd4), 5'd4);
    set_entry(4,  rtype_word(7'h00, 5'd2, 5'd3, 3'b111, 5'd5), 5'd5);
    set_entry(5,  rtype_word(7'h00, 5'd5, 5'd4, 3'b110, 5'd6), 5'd6);
    set_entry(6,  rtype_word(7'h00, 5'd1, 5'd6, 3'b100, 5'd7), 5'd7);
    set_entry(7,  rtype_word(7'h00, 5'd3, 5'd4, 3'b010, 5'd8), 5'd8);
    set_entry(8,  lui_word(20'hABCDE, 5'd9), 5'd9);
    set_entry(9,  rtype_word(7'h00, 5'd7, 5'd9, 3'b000, 5'd10), 5'd10);
    set_entry(10, addi_word(imm_c, 5'd1, 5'd0), 5'd0); // Write to x0
    set_entry(11, rtype_word(7'h00, 5'd2, 5'd0, 3'b000, 5'd11), 5'd11);
    set_entry(12, branch_word(1'b0, 5'd1, 5'd1, 13'd12), 5'd0); // Taken, skips two
    set_entry(13, addi_word(12'd1, 5'd0, 5'd12), 5'd12);
    set_entry(14, addi_word(12'd2, 5'd0, 5'd13), 5'd13);
    set_entry(15, branch_word(1'b1, 5'd1, 5'd1, 13'd8), 5'd0); // Never taken
    set_entry(16, branch_word(1'b1, 5'd2, 5'd3, 13'd8), 5'd0);
    set_entry(17, addi_word(12'd3, 5'd0, 5'd14), 5'd14);
    set_entry(18, jal_word(5'd15, 21'd8), 5'd15);
    set_entry(19, addi_word(12'd4, 5'd0, 5'd16), 5'd16);
    set_entry(20, rtype_word(7'h00, 5'd4, 5'd0, 3'b010, 5'd17), 5'd17);
    set_entry(21, rtype_word(7'h00, 5'd17, 5'd15, 3'b000, 5'd18), 5'd18);
  endtask

  // ISA model of the subset, fills the expected retire queues
  task automatic run_reference();
    logic [`RV_XLEN-1:0] regs [32];
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] nxt;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] data;
    logic [31:0]         w;
    logic                wr;
    int                  idx;
    int                  steps;
    foreach (regs[i]) regs[i] = '0;
    pc    = `RV_RESET_PC;
    steps = 0;
    while ((pc >> 2) < NUM_INSTR && steps < 4 * NUM_INSTR) begin
      idx  = pc >> 2;
      w    = prog_word[idx];
      a    = regs[w[19:15]];
      b    = regs[w[24:20]];
      data = '0;
      wr   = 1'b0;
      nxt  = pc + `RV_PC_STEP;
      case (w[6:0])
        7'b0110011: begin
          wr = 1'b1;
          case (w[14:12])
            3'b000:  data = w[30] ? a - b : a + b;
            3'b010:  data = ($signed(a) < $signed(b)) ? 1 : 0;
            3'b100:  data = a ^ b;
            3'b110:  data = a | b;
            3'b111:  data = a & b;
            default: wr = 1'b0;
          endcase
        end
        7'b0010011: begin
          wr   = (w[14:12] == 3'b000);
          data = a + {{20{w[31]}}, w[31:20]};
        end
        7'b0110111: begin
          wr   = 1'b1;
          data = {w[31:12], 12'b0};
        end
        7'b1100011: begin
          if (w[14:13] == 2'b00 && ((a == b) != w[12]))
            nxt = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        7'b1101111: begin
          wr   = 1'b1;
          data = pc + `RV_PC_STEP; // Link
          nxt  = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        default: ;
      endcase
      if (wr && w[11:7] != 5'd0) regs[w[11:7]] = data;
      exp_pc_q.push_back(pc);
      exp_rd_q.push_back(prog_rd[idx]);
      exp_data_q.push_back(prog_rd[idx] != 5'd0 ? data : '0);
      pc    = nxt;
      steps = steps + 1;
    end
  endtask

  task automatic check_retire();
    logic [`RV_XLEN-1:0] pc;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] data;
    if (exp_pc_q.size() == 0) begin
      errors = errors + 1;
      $display("Unexpected retire at pc %h with no retirement left in the model", retire_pc_o);
      return;
    end
    pc      = exp_pc_q.pop_front();
    rd      = exp_rd_q.pop_front();
    data    = exp_data_q.pop_front();
    checked = checked + 1;
    if (retire_pc_o !== pc) begin
      errors = errors + 1;
      $display("MISMATCH retire_pc_o: got %h, expected %h", retire_pc_o, pc);
    end
    if (retire_rd_o !== rd) begin
      errors = errors + 1;
      $display("MISMATCH retire_rd_o: got %h, expected %h (pc %h)", retire_rd_o, rd, pc);
    end
    if (retire_data_o !== data) begin
      errors = errors + 1;
      $display("MISMATCH retire_data_o: got %h, expected %h (pc %h)", retire_data_o, data, pc);
    end
  endtask

  // Instruction memory, one cycle from request to word
  always @(posedge clk_i) begin
    if (imem_req_o) begin
      if (imem_addr_o < NUM_INSTR * 4) imem_data_i <= prog_word[imem_addr_o >> 2];
      else imem_data_i <= NOP_WORD;
    end
  end

  always @(negedge clk_i) begin
    if (rst_n_i && !start_i && (imem_req_o !== 1'b0 || retire_valid_o !== 1'b0)) begin
      errors = errors + 1;
      $display("Core active before start_i: imem_req_o %b, retire_valid_o %b",
               imem_req_o, retire_valid_o);
    end
    if (retire_valid_o === 1'b1) check_retire();
  end

  initial begin
    rst_n_i     = 1'b0;
    start_i     = 1'b0;
    imem_data_i = NOP_WORD;
    errors      = 0;
    checked     = 0;
    void'($urandom(66));
    load_program();
    run_reference();
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    start_i <= 1'b1;
    while (exp_pc_q.size() != 0) @(posedge clk_i);
    $display("Checked %0d retirements, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles with %0d expected retirements never seen",
             WATCHDOG_CYCLES, exp_pc_q.size());
    $display("Checked %0d retirements, %0d errors", checked, errors + 1);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== rv_lite.f ====
+incdir+logic
logic/rv_lite_pkg.sv
logic/exec_if.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/writeback_unit.sv
logic/rv_lite_core.sv
bench/tb_rv_lite_core.sv

// ==== Bender.yml ====
package:
  name: rv_lite

export_include_dirs:
  - logic

sources:
  - files:
      - logic/rv_lite_pkg.sv
      - logic/exec_if.sv
      - logic/fetch_unit.sv
      - logic/decode_unit.sv
      - logic/alu_unit.sv
      - logic/branch_unit.sv
      - logic/writeback_unit.sv
      - logic/rv_lite_core.sv
  - target: test
    files:
      - bench/tb_rv_lite_core.sv
